/* Bender.yml */
package:
  name: resp_dispatch

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/resp_dispatch_pkg.sv
      - logic/resp_sync_fifo.sv
      - logic/resp_dispatch_control.sv
      - logic/resp_demux.sv
      - logic/resp_dispatch_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/resp_dispatch_checker.sv
      - tb/resp_dispatch_tb.sv

/* include/resp_dispatch_defs.svh */
// ------------------------------------------------
// Response dispatcher parameters
// ------------------------------------------------

`ifndef RESP_DISPATCH_DEFS_SVH
`define RESP_DISPATCH_DEFS_SVH

// Number of requestor ports (2 to 8)
`define RESP_NUM_REQUESTOR 4

// Payload word and echoed request tag
`define RESP_DATA_WIDTH 32
`define RESP_TAG_WIDTH 8

// Queue depth, must be a power of two
`define RESP_FIFO_DEPTH 16

// Fill level that raises prog_full
`define RESP_PROG_THRESH 12

// Queue init window after reset
`define RESP_SETUP_CYCLES 8

`endif

/* logic/resp_demux.sv */
// ------------------------------------------------
// Multicast output demux
// ------------------------------------------------

`timescale 1ns/10ps

`include "resp_dispatch_defs.svh"

module resp_demux
  import resp_dispatch_pkg::*;
(
  input  logic         ap_clk,
  input  logic         areset_control,
  input  resp_packet_t head,
  input  logic         head_fire,
  output resp_packet_t response_out [`RESP_NUM_REQUESTOR-1:0]
);

logic                           head_valid_q;
resp_payload_t                  head_payload_q;
logic [`RESP_NUM_REQUESTOR-1:0] out_valid;
resp_payload_t                  out_payload;

// ------------------------------------------------
// Head register
// ------------------------------------------------
always_ff @(posedge ap_clk) begin
  if (areset_control) begin
    head_valid_q <= 1'b0;
  end else begin
    head_valid_q <= head_fire & head.valid;
  end
end

always_ff @(posedge ap_clk) begin
  if (head_fire) begin
    head_payload_q <= head.payload;
  end
end

// ------------------------------------------------
// Per-port outputs
// ------------------------------------------------

// Only the ports named in the mask see the strobe
always_ff @(posedge ap_clk) begin
  if (areset_control) begin
    out_valid <= '0;
  end else begin
    out_valid <= {`RESP_NUM_REQUESTOR{head_valid_q}} & head_payload_q.meta.mask;
  end
end

// One payload register shared by all ports
always_ff @(posedge ap_clk) begin
  if (head_valid_q) begin
    out_payload <= head_payload_q;
  end
end

for (genvar i = 0; i < `RESP_NUM_REQUESTOR; i++) begin : g_port
  assign response_out[i] = '{valid: out_valid[i], payload: out_payload};
end

endmodule : resp_demux

/* logic/resp_dispatch_control.sv */
// ------------------------------------------------
// Dispatcher control and setup FSM
// ------------------------------------------------

`timescale 1ns/10ps

`include "resp_dispatch_defs.svh"

module resp_dispatch_control
  import resp_dispatch_pkg::*;
(
  input  logic                           ap_clk,
  input  logic                           areset_control,
  input  resp_packet_t                   response_in,
  input  logic [`RESP_NUM_REQUESTOR-1:0] requestor_ready,
  input  resp_packet_t                   fifo_head,
  input  resp_fifo_status_t              fifo_raw_status,
  output logic                           push,
  output resp_payload_t                  push_data,
  output logic                           pop,
  output logic                           head_fire,
  output resp_fifo_status_t              fifo_status,
  output logic                           setup_busy
);

localparam int SETUP_W = $clog2(`RESP_SETUP_CYCLES + 1);

localparam logic [SETUP_W-1:0] SETUP_LAST = SETUP_W'(`RESP_SETUP_CYCLES - 1);

dispatch_state_e                state;
logic [SETUP_W-1:0]             setup_count;
resp_packet_t                   response_in_q;
logic [`RESP_NUM_REQUESTOR-1:0] ready_q;
logic                           in_run;
logic                           head_addressed;
logic                           head_ready;

assign in_run = (state == ST_RUN);

// ------------------------------------------------
// Setup window
// ------------------------------------------------
always_ff @(posedge ap_clk) begin
  if (areset_control) begin
    state       <= ST_SETUP;
    setup_count <= '0;
    setup_busy  <= 1'b1;
  end else begin
    case (state)
      ST_SETUP: begin
        if (setup_count == SETUP_LAST) begin
          state      <= ST_RUN;
          setup_busy <= 1'b0;
        end else begin
          setup_count <= setup_count + 1'b1;
        end
      end
      // Stays here until the next reset
      ST_RUN: begin
        state <= ST_RUN;
      end
      default: begin
        state <= ST_SETUP;
      end
    endcase
  end
end

// ------------------------------------------------
// Input and ready registers
// ------------------------------------------------

// Strobes seen during setup never enter the queue
always_ff @(posedge ap_clk) begin
  if (areset_control) begin
    response_in_q.valid <= 1'b0;
    ready_q             <= '0;
  end else begin
    response_in_q.valid <= response_in.valid & in_run;
    ready_q             <= requestor_ready;
  end
end

always_ff @(posedge ap_clk) begin
  response_in_q.payload <= response_in.payload;
end

// Zero mask packets are dropped here
assign push = response_in_q.valid & (|response_in_q.payload.meta.mask)
            & in_run & ~fifo_raw_status.full;
assign push_data = response_in_q.payload;

// ------------------------------------------------
// Pop decision
// ------------------------------------------------

// Strict head-of-line order, all addressed ports must be ready
assign head_addressed = fifo_head.valid & (|fifo_head.payload.meta.mask);
assign head_ready     = resp_mask_ready(fifo_head.payload.meta.mask, ready_q);

assign pop       = in_run & head_addressed & head_ready;
assign head_fire = pop;

// Status lags the queue count by one cycle
always_ff @(posedge ap_clk) begin
  if (areset_control) begin
    fifo_status <= RESP_STATUS_RESET;
  end else begin
    fifo_status <= fifo_raw_status;
  end
end

endmodule : resp_dispatch_control

/* logic/resp_dispatch_pkg.sv */
// ------------------------------------------------
// Response dispatcher types
// ------------------------------------------------

`include "resp_dispatch_defs.svh"

package resp_dispatch_pkg;

// ------------------------------------------------
// Packet layout
// ------------------------------------------------

// Routing info echoed from the request
typedef struct packed {
  logic [`RESP_NUM_REQUESTOR-1:0] mask;
  logic [`RESP_TAG_WIDTH-1:0]     tag;
} resp_meta_t;

typedef struct packed {
  resp_meta_t                  meta;
  logic [`RESP_DATA_WIDTH-1:0] data;
} resp_payload_t;

typedef struct packed {
  logic          valid;
  resp_payload_t payload;
} resp_packet_t;

// ------------------------------------------------
// Queue status and control state
// ------------------------------------------------

typedef struct packed {
  logic full;
  logic prog_full;
  logic empty;
} resp_fifo_status_t;

typedef enum logic [0:0] {
  ST_SETUP = 1'b0,
  ST_RUN   = 1'b1
} dispatch_state_e;

// Status seen while the queue is held in reset
localparam resp_fifo_status_t RESP_STATUS_RESET = '{
  full:      1'b0,
  prog_full: 1'b0,
  empty:     1'b1
};

// True when every port named in mask can take the packet
function automatic logic resp_mask_ready(
  input logic [`RESP_NUM_REQUESTOR-1:0] mask,
  input logic [`RESP_NUM_REQUESTOR-1:0] ready
);
  return ((mask & ready) == mask);
endfunction

endpackage : resp_dispatch_pkg

/* logic/resp_dispatch_top.sv */
// ------------------------------------------------
// Memory response dispatcher
// ------------------------------------------------

`timescale 1ns/10ps

`include "resp_dispatch_defs.svh"

module resp_dispatch_top
  import resp_dispatch_pkg::*;
(
  input  logic                           ap_clk,
  input  logic                           areset_control,
  input  resp_packet_t                   response_in,
  input  logic [`RESP_NUM_REQUESTOR-1:0] requestor_ready,
  output resp_packet_t                   response_out [`RESP_NUM_REQUESTOR-1:0],
  output resp_fifo_status_t              fifo_status,
  output logic                           setup_busy
);

// Control to queue
logic          push;
resp_payload_t push_data;
logic          pop;
logic          head_fire;

// Queue to control and demux
resp_packet_t      fifo_head;
resp_fifo_status_t fifo_raw_status;

resp_dispatch_control u_control (
  .ap_clk          (ap_clk),
  .areset_control  (areset_control),
  .response_in     (response_in),
  .requestor_ready (requestor_ready),
  .fifo_head       (fifo_head),
  .fifo_raw_status (fifo_raw_status),
  .push            (push),
  .push_data       (push_data),
  .pop             (pop),
  .head_fire       (head_fire),
  .fifo_status     (fifo_status),
  .setup_busy      (setup_busy)
);

resp_sync_fifo #(
  .DEPTH       (`RESP_FIFO_DEPTH),
  .PROG_THRESH (`RESP_PROG_THRESH)
) u_fifo (
  .ap_clk         (ap_clk),
  .areset_control (areset_control),
  .push           (push),
  .push_data      (push_data),
  .pop            (pop),
  .head           (fifo_head),
  .raw_status     (fifo_raw_status)
);

resp_demux u_demux (
  .ap_clk         (ap_clk),
  .areset_control (areset_control),
  .head           (fifo_head),
  .head_fire      (head_fire),
  .response_out   (response_out)
);

endmodule : resp_dispatch_top

/* logic/resp_sync_fifo.sv */
// ------------------------------------------------
// First-word-fall-through packet queue
// ------------------------------------------------

`timescale 1ns/10ps

`include "resp_dispatch_defs.svh"

module resp_sync_fifo
  import resp_dispatch_pkg::*;
#(
  parameter int DEPTH       = `RESP_FIFO_DEPTH,
  parameter int PROG_THRESH = `RESP_PROG_THRESH
) (
  input  logic              ap_clk,
  input  logic              areset_control,
  input  logic              push,
  input  resp_payload_t     push_data,
  input  logic              pop,
  output resp_packet_t      head,
  output resp_fifo_status_t raw_status
);

localparam int ADDR_W  = $clog2(DEPTH);
localparam int COUNT_W = ADDR_W + 1;

localparam logic [COUNT_W-1:0] COUNT_FULL = COUNT_W'(DEPTH);
localparam logic [COUNT_W-1:0] COUNT_PROG = COUNT_W'(PROG_THRESH);

// ------------------------------------------------
// Storage and pointers
// ------------------------------------------------
resp_payload_t      mem [DEPTH-1:0];
logic [ADDR_W-1:0]  wr_ptr;
logic [ADDR_W-1:0]  rd_ptr;
logic [COUNT_W-1:0] count;

logic full_int;
logic empty_int;
logic wr_en;
logic rd_en;

assign full_int  = (count == COUNT_FULL);
assign empty_int = (count == '0);

// Guard against overflow and underflow
assign wr_en = push & ~full_int;
assign rd_en = pop & ~empty_int;

always_ff @(posedge ap_clk) begin
  if (areset_control) begin
    wr_ptr <= '0;
    rd_ptr <= '0;
  end else begin
    if (wr_en) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
    if (rd_en) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end
end

// Occupancy, simultaneous push and pop leave it unchanged
always_ff @(posedge ap_clk) begin
  if (areset_control) begin
    count <= '0;
  end else begin
    case ({wr_en, rd_en})
      2'b10: begin
        count <= count + 1'b1;
      end
      2'b01: begin
        count <= count - 1'b1;
      end
      default: begin
        count <= count;
      end
    endcase
  end
end

always_ff @(posedge ap_clk) begin
  if (wr_en) begin
    mem[wr_ptr] <= push_data;
  end
end

// ------------------------------------------------
// Head and status
// ------------------------------------------------

// Oldest entry shows without a read request
assign head.valid   = ~empty_int;
assign head.payload = mem[rd_ptr];

assign raw_status.full      = full_int;
assign raw_status.prog_full = (count >= COUNT_PROG);
assign raw_status.empty     = empty_int;

endmodule : resp_sync_fifo

/* resp_dispatch.f */
+incdir+include
logic/resp_dispatch_pkg.sv
logic/resp_sync_fifo.sv
logic/resp_dispatch_control.sv
logic/resp_demux.sv
logic/resp_dispatch_top.sv
tb/resp_dispatch_checker.sv
tb/resp_dispatch_tb.sv

/* tb/resp_dispatch_checker.sv */
// ------------------------------------------------
// Dispatcher protocol assertions
// ------------------------------------------------

`timescale 1ns/10ps

`include "resp_dispatch_defs.svh"

module resp_dispatch_checker
  import resp_dispatch_pkg::*;
(
  input logic              ap_clk,
  input logic              areset_control,
  input resp_packet_t      response_out [`RESP_NUM_REQUESTOR-1:0],
  input resp_fifo_status_t fifo_status,
  input logic              setup_busy
);

int unsigned                    fail_count;
logic [`RESP_NUM_REQUESTOR-1:0] out_valid;
logic [`RESP_NUM_REQUESTOR-1:0] out_mask;

initial begin
  fail_count = 0;
end

// All ports share one payload register
assign out_mask = response_out[0].payload.meta.mask;

// ------------------------------------------------
// Setup window
// ------------------------------------------------
setup_length_a: assert property (@(posedge ap_clk)
  $fell(areset_control) |-> setup_busy [*`RESP_SETUP_CYCLES] ##1 !setup_busy)
  else begin
    $error("setup_busy window has the wrong length");
    fail_count++;
  end

setup_stays_low_a: assert property (@(posedge ap_clk) disable iff (areset_control)
  !setup_busy |=> !setup_busy)
  else begin
    $error("setup_busy rose again after the setup window");
    fail_count++;
  end

quiet_in_setup_a: assert property (@(posedge ap_clk) setup_busy |-> (out_valid == '0))
  else begin
    $error("response valid while setup_busy is high");
    fail_count++;
  end

quiet_in_reset_a: assert property (@(posedge ap_clk) areset_control |=> (out_valid == '0))
  else begin
    $error("response valid during reset");
    fail_count++;
  end

// ------------------------------------------------
// Output routing and status
// ------------------------------------------------
for (genvar i = 0; i < `RESP_NUM_REQUESTOR; i++) begin : g_port
  assign out_valid[i] = response_out[i].valid;

  port_mask_a: assert property (@(posedge ap_clk) disable iff (areset_control)
    response_out[i].valid |-> out_mask[i])
    else begin
      $error("valid on a port that the mask does not name");
      fail_count++;
    end
end

multicast_together_a: assert property (@(posedge ap_clk) disable iff (areset_control)
  (|out_valid) |-> (out_valid == out_mask))
  else begin
    $error("named ports did not strobe in the same cycle");
    fail_count++;
  end

full_empty_a: assert property (@(posedge ap_clk) disable iff (areset_control)
  !(fifo_status.full && fifo_status.empty))
  else begin
    $error("queue reports full and empty together");
    fail_count++;
  end

endmodule : resp_dispatch_checker

/* tb/resp_dispatch_tb.sv */
// ------------------------------------------------
// Response dispatcher testbench
// ------------------------------------------------

`timescale 1ns/10ps

`include "resp_dispatch_defs.svh"

module resp_dispatch_tb
  import resp_dispatch_pkg::*;
();

localparam int NREQ        = `RESP_NUM_REQUESTOR;
localparam int TW          = `RESP_TAG_WIDTH;
localparam int DW          = `RESP_DATA_WIDTH;
localparam int SETUP_PKTS  = 4;
localparam int UNI_PKTS    = 40;
localparam int MULTI_PKTS  = 24;
localparam int ZERO_PKTS   = 24;
localparam int BP_PKTS     = `RESP_FIFO_DEPTH + 4;
localparam int TOTAL_PKTS  = SETUP_PKTS + UNI_PKTS + MULTI_PKTS + ZERO_PKTS + BP_PKTS;
// Worst case per packet, covers gaps, drains and the blocked hold
localparam int DRAIN_BOUND = 12;
localparam int CYCLE_LIMIT = 10 + `RESP_SETUP_CYCLES + TOTAL_PKTS * DRAIN_BOUND;

logic              ap_clk;
logic              areset_control;
resp_packet_t      response_in;
logic [NREQ-1:0]   requestor_ready;
resp_packet_t      response_out [NREQ-1:0];
resp_fifo_status_t fifo_status;
logic              setup_busy;

// Expected deliveries, one queue per port
resp_payload_t exp_q [NREQ][$];
logic [31:0]   rng_state;
string         test_name;
int unsigned   errors;
int unsigned   cycle_count;
int unsigned   setup_seen;
int unsigned   bp_count;
logic          blocked;

resp_dispatch_top u_resp_dispatch_top (.*);

bind resp_dispatch_top resp_dispatch_checker u_checker (.*);

always #2 ap_clk = ~ap_clk;

always @(posedge ap_clk) begin
  cycle_count <= cycle_count + 1;
end

function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

task automatic next_rand(output logic [31:0] value);
  rng_state = lcg_next(rng_state);
  value     = rng_state;
endtask

function automatic logic [NREQ-1:0] one_hot_mask(input logic [31:0] r);
  return NREQ'(1) << (r[31:16] % NREQ);
endfunction

// At least two bits set
function automatic logic [NREQ-1:0] multi_mask(input logic [31:0] r);
  logic [NREQ-1:0] m;
  logic [NREQ-1:0] pair;
  m    = r[31 -: NREQ];
  pair = NREQ'(3);
  if ($countones(m) < 2) begin
    m = m | (pair << (r[23:16] % (NREQ - 1)));
  end
  return m;
endfunction

task automatic check_value(input string what, input logic [63:0] expected,
                           input logic [63:0] actual);
  assert (expected === actual) else begin
    errors++;
    $display("mismatch %s %s expected %0h actual %0h", test_name, what, expected, actual);
  end
endtask

task automatic send_packet(input logic [NREQ-1:0] mask, input logic accepted);
  resp_packet_t pkt;
  logic [31:0]  r;
  next_rand(r);
  pkt.valid             = 1'b1;
  pkt.payload.meta.mask = mask;
  pkt.payload.meta.tag  = TW'(r >> 8);
  next_rand(r);
  pkt.payload.data = DW'(r);
  @(posedge ap_clk);
  response_in <= pkt;
  for (int i = 0; i < NREQ; i++) begin
    if (accepted && mask[i]) begin
      exp_q[i].push_back(pkt.payload);
    end
  end
endtask

task automatic drive_idle(input int cycles);
  for (int i = 0; i < cycles; i++) begin
    @(posedge ap_clk);
    response_in.valid <= 1'b0;
  end
endtask

task automatic wait_drained();
  logic busy;
  busy = 1'b1;
  while (busy) begin
    @(posedge ap_clk);
    busy = !fifo_status.empty;
    for (int i = 0; i < NREQ; i++) begin
      if (exp_q[i].size() != 0) begin
        busy = 1'b1;
      end
    end
  end
endtask

// ------------------------------------------------
// Output monitor
// ------------------------------------------------
always @(negedge ap_clk) begin
  for (int i = 0; i < NREQ; i++) begin
    if (response_out[i].valid) begin
      assert (!blocked) else begin
        errors++;
        $display("port %0d delivered a packet past a blocked head in %s", i, test_name);
      end
      assert (exp_q[i].size() != 0) else begin
        errors++;
        $display("port %0d delivered a packet nobody expected in %s", i, test_name);
      end
      if (exp_q[i].size() != 0) begin
        check_value($sformatf("port %0d payload", i), exp_q[i].pop_front(),
                    response_out[i].payload);
      end
    end
  end
  if (!areset_control && setup_busy) begin
    setup_seen++;
  end
end

initial begin
  wait (cycle_count >= CYCLE_LIMIT);
  $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
  $display("Checks failed");
  $finish;
end

// ------------------------------------------------
// Test sequence
// ------------------------------------------------
initial begin
  logic [31:0]     r;
  logic [NREQ-1:0] m;
  int unsigned     total;
  ap_clk          = 1'b0;
  areset_control  = 1'b1;
  response_in     = '0;
  requestor_ready = '1;
  rng_state       = 32'hdf98_008b;
  errors          = 0;
  setup_seen      = 0;
  blocked         = 1'b0;
  test_name       = "setup";
  repeat (10) @(posedge ap_clk);
  areset_control <= 1'b0;

  // Strobes inside the setup window must vanish
  for (int n = 0; n < SETUP_PKTS; n++) begin
    next_rand(r);
    send_packet(one_hot_mask(r), 1'b0);
  end
  drive_idle(1);
  while (setup_busy) begin
    @(posedge ap_clk);
  end
  check_value("busy cycles", `RESP_SETUP_CYCLES, setup_seen);

  test_name = "unicast";
  for (int n = 0; n < UNI_PKTS; n++) begin
    next_rand(r);
    send_packet(one_hot_mask(r), 1'b1);
    if (r[7]) drive_idle(1);
  end
  drive_idle(1);
  wait_drained();

  test_name = "multicast";
  for (int n = 0; n < MULTI_PKTS; n++) begin
    next_rand(r);
    send_packet(multi_mask(r), 1'b1);
  end
  drive_idle(1);
  wait_drained();

  test_name = "zero_mask";
  for (int n = 0; n < ZERO_PKTS; n++) begin
    next_rand(r);
    m = r[10] ? one_hot_mask(r) : multi_mask(r);
    send_packet((r[9:8] == 2'b00) ? '0 : m, 1'b1);
  end
  drive_idle(1);
  wait_drained();

  // Port 0 stalls the head, the queue fills behind it
  test_name = "backpressure";
  bp_count  = 0;
  @(posedge ap_clk);
  requestor_ready <= ~NREQ'(1);
  drive_idle(3);
  blocked = 1'b1;
  for (int n = 0; n < BP_PKTS; n++) begin
    next_rand(r);
    m = (n == 0) ? (multi_mask(r) | NREQ'(1)) : multi_mask(r);
    send_packet(m, bp_count < `RESP_FIFO_DEPTH);
    bp_count++;
    if (n == `RESP_PROG_THRESH - 1) begin
      drive_idle(4);
      @(negedge ap_clk);
      check_value("prog_full status", 3'b010, fifo_status);
    end
  end
  drive_idle(4);
  @(negedge ap_clk);
  check_value("full status", 3'b110, fifo_status);
  drive_idle(8);
  blocked = 1'b0;
  @(posedge ap_clk);
  requestor_ready <= '1;
  wait_drained();
  @(negedge ap_clk);
  check_value("drained status", 3'b001, fifo_status);

  drive_idle(4);
  total = errors + u_resp_dispatch_top.u_checker.fail_count;
  $display("errors: %0d testbench, %0d assertion", errors,
           u_resp_dispatch_top.u_checker.fail_count);
  if (total == 0) begin
    $display("All checks passed");
  end else begin
    $display("Checks failed");
  end
  $finish;
end

endmodule : resp_dispatch_tb
